//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = tb_dcache
FILELIST = files.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- files.f
hw/dcache_cfg_pkg.sv
hw/dcache_bus_pkg.sv
hw/dcache_dpram.sv
hw/dcache_lru.sv
hw/dcache_ctrl.sv
hw/dcache_mem_port.sv
hw/dcache_top.sv
sim/tb_mem_model.sv
sim/tb_dcache.sv

//--- hw/dcache_bus_pkg.sv
// Bus-side types of the data cache.
// Wishbone classic request/response, invalidate request and memory port commands.
package dcache_bus_pkg;

   // Same shape on the CPU and the memory side
   typedef struct packed {
      logic cyc;
      logic stb;
      logic we;
      logic [dcache_cfg_pkg::SEL_W-1:0] sel;
      logic [dcache_cfg_pkg::ADDR_W-1:0] adr;
      logic [dcache_cfg_pkg::DATA_W-1:0] dat;
   } wb_req_t;

   typedef struct packed {
      logic ack;
      logic [dcache_cfg_pkg::DATA_W-1:0] dat;
   } wb_rsp_t;

   // Block invalidate, byte address
   typedef struct packed {
      logic cyc;
      logic stb;
      logic [dcache_cfg_pkg::ADDR_W-1:0] adr;
   } inv_req_t;

   // Controller to memory port, start is a single-cycle pulse
   typedef struct packed {
      logic start;
      logic write;
      logic [dcache_cfg_pkg::ADDR_W-1:0] adr;
      logic [dcache_cfg_pkg::DATA_W-1:0] dat;
      logic [dcache_cfg_pkg::SEL_W-1:0] sel;
   } mem_cmd_t;

   // One refill word back to the controller
   typedef struct packed {
      logic valid;
      logic [dcache_cfg_pkg::BLOCK_W-3:0] idx;
      logic [dcache_cfg_pkg::DATA_W-1:0] dat;
   } fill_word_t;

endpackage

//--- hw/dcache_cfg_pkg.sv
// Geometry of the two-way write-through data cache.
// Address field widths and the tag RAM entry layout live here.
package dcache_cfg_pkg;

   // Bus word
   localparam int ADDR_W = 32;
   localparam int DATA_W = 32;
   localparam int SEL_W = 4;

   // 2 ways, 16 sets, 16-byte blocks
   localparam int NUM_WAYS = 2;
   localparam int BLOCK_W = 4;
   localparam int SET_W = 4;
   localparam int WORDS_PER_BLOCK = 4;
   localparam int TAG_W = ADDR_W - BLOCK_W - SET_W;
   localparam int WAY_ADR_W = SET_W + BLOCK_W - 2;

   // One history bit per pair of ways
   localparam int LRU_W = NUM_WAYS * (NUM_WAYS - 1) / 2;

   typedef struct packed {
      logic valid;
      logic [TAG_W-1:0] tag;
   } tag_way_t;

   // Tag RAM word, LRU history on top
   typedef struct packed {
      logic [LRU_W-1:0] lru;
      tag_way_t [NUM_WAYS-1:0] way;
   } tag_set_t;

   typedef logic [NUM_WAYS-1:0] way_vec_t;

endpackage

//--- hw/dcache_ctrl.sv
// Cache FSM. Tag compare, hit way select, byte merge and tag/LRU updates.
// Reads refill on a miss, writes always go through to memory.
`timescale 1ns/1ns

module dcache_ctrl (
   input  logic                                   clk,
   input  logic                                   rst,
   input  dcache_bus_pkg::wb_req_t                cpu_req_i,
   output dcache_bus_pkg::wb_rsp_t                cpu_rsp_o,
   input  dcache_bus_pkg::inv_req_t               inv_req_i,
   output logic                                   inv_ack_o,
   output logic [dcache_cfg_pkg::SET_W-1:0]       tag_raddr_o,
   output logic [dcache_cfg_pkg::SET_W-1:0]       tag_waddr_o,
   output logic                                   tag_we_o,
   output dcache_cfg_pkg::tag_set_t               tag_din_o,
   input  dcache_cfg_pkg::tag_set_t               tag_dout_i,
   output logic [dcache_cfg_pkg::WAY_ADR_W-1:0]   way_raddr_o,
   output logic [dcache_cfg_pkg::WAY_ADR_W-1:0]   way_waddr_o,
   output dcache_cfg_pkg::way_vec_t               way_we_o,
   output logic [dcache_cfg_pkg::DATA_W-1:0]      way_din_o,
   input  logic [dcache_cfg_pkg::NUM_WAYS-1:0][dcache_cfg_pkg::DATA_W-1:0] way_dout_i,
   output logic [dcache_cfg_pkg::LRU_W-1:0]       lru_cur_o,
   output dcache_cfg_pkg::way_vec_t               lru_access_o,
   input  logic [dcache_cfg_pkg::LRU_W-1:0]       lru_next_i,
   input  dcache_cfg_pkg::way_vec_t               lru_way_i,
   output dcache_bus_pkg::mem_cmd_t               cmd_o,
   input  dcache_bus_pkg::fill_word_t             fill_i,
   input  logic                                   mem_done_i
);

   typedef enum logic [2:0] {IDLE, LOOKUP, REFILL, WRITE_THRU, INVALIDATE} state_t;

   state_t state_q;
   logic ack_q;
   logic inv_ack_q;
   logic [dcache_cfg_pkg::DATA_W-1:0] dat_q;
   dcache_cfg_pkg::way_vec_t lru_way_q;
   dcache_cfg_pkg::tag_set_t tags_q;

   // Address fields, held stable by the master until ack
   logic [dcache_cfg_pkg::TAG_W-1:0] cpu_tag;
   logic [dcache_cfg_pkg::SET_W-1:0] cpu_set;
   logic [dcache_cfg_pkg::BLOCK_W-3:0] cpu_word;
   logic [dcache_cfg_pkg::SET_W-1:0] inv_set;

   dcache_cfg_pkg::way_vec_t way_hit;
   logic hit;
   logic [dcache_cfg_pkg::DATA_W-1:0] hit_dat;
   logic [dcache_cfg_pkg::DATA_W-1:0] merged;

   assign cpu_tag = cpu_req_i.adr[dcache_cfg_pkg::ADDR_W-1 -: dcache_cfg_pkg::TAG_W];
   assign cpu_set = cpu_req_i.adr[dcache_cfg_pkg::BLOCK_W +: dcache_cfg_pkg::SET_W];
   assign cpu_word = cpu_req_i.adr[2 +: dcache_cfg_pkg::BLOCK_W-2];
   assign inv_set = inv_req_i.adr[dcache_cfg_pkg::BLOCK_W +: dcache_cfg_pkg::SET_W];

   // RAMs read the CPU address every cycle
   assign tag_raddr_o = cpu_set;
   assign way_raddr_o = {cpu_set, cpu_word};
   assign tag_waddr_o = (state_q == INVALIDATE) ? inv_set : cpu_set;
   assign way_waddr_o = {cpu_set, (state_q == REFILL) ? fill_i.idx : cpu_word};

   // Tag compare and hit data, only meaningful in LOOKUP
   always_comb begin
      hit_dat = '0;
      for (int i = 0; i < dcache_cfg_pkg::NUM_WAYS; i++) begin
         way_hit[i] = tag_dout_i.way[i].valid && (tag_dout_i.way[i].tag == cpu_tag);
         if (way_hit[i]) begin
            hit_dat |= way_dout_i[i];
         end
      end
      hit = |way_hit;
      // Byte lanes not selected keep the cached bytes
      for (int b = 0; b < dcache_cfg_pkg::SEL_W; b++) begin
         merged[8*b +: 8] = cpu_req_i.sel[b] ? cpu_req_i.dat[8*b +: 8] : hit_dat[8*b +: 8];
      end
   end

   // History source: live tags on lookup, saved tags during refill
   assign lru_cur_o = (state_q == REFILL) ? tags_q.lru : tag_dout_i.lru;
   assign lru_access_o = (state_q == REFILL) ? lru_way_q : way_hit;

   // One start pulse, issued from LOOKUP only
   assign cmd_o = '{start: (state_q == LOOKUP) && (cpu_req_i.we || !hit),
                    write: cpu_req_i.we,
                    adr: cpu_req_i.adr,
                    dat: cpu_req_i.dat,
                    sel: cpu_req_i.sel};

   always_comb begin
      tag_we_o = 1'b0;
      tag_din_o = tag_dout_i;
      tag_din_o.lru = lru_next_i;
      way_we_o = '0;
      way_din_o = merged;
      case (state_q)
         LOOKUP: begin
            if (hit) begin
               // Hit, read or write, refreshes the history
               tag_we_o = 1'b1;
               if (cpu_req_i.we) begin
                  way_we_o = way_hit;
               end
            end else if (!cpu_req_i.we) begin
               // Victim way goes invalid until the refill completes
               tag_we_o = 1'b1;
               tag_din_o.lru = tag_dout_i.lru;
               for (int i = 0; i < dcache_cfg_pkg::NUM_WAYS; i++) begin
                  if (lru_way_i[i]) begin
                     tag_din_o.way[i].valid = 1'b0;
                  end
               end
            end
         end
         REFILL: begin
            way_din_o = fill_i.dat;
            if (fill_i.valid) begin
               way_we_o = lru_way_q;
            end
            if (mem_done_i) begin
               tag_we_o = 1'b1;
               tag_din_o = tags_q;
               tag_din_o.lru = lru_next_i;
               for (int i = 0; i < dcache_cfg_pkg::NUM_WAYS; i++) begin
                  if (lru_way_q[i]) begin
                     tag_din_o.way[i] = '{valid: 1'b1, tag: cpu_tag};
                  end
               end
            end
         end
         INVALIDATE: begin
            // Lazy invalidation clears every way of the set
            tag_we_o = 1'b1;
            tag_din_o = '0;
         end
         default: begin
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state_q <= IDLE;
         ack_q <= 1'b0;
         inv_ack_q <= 1'b0;
      end else begin
         ack_q <= 1'b0;
         inv_ack_q <= 1'b0;
         case (state_q)
            // Requests seen in the ack cycle are the finished ones
            IDLE: begin
               if (inv_req_i.cyc && inv_req_i.stb && !inv_ack_q) begin
                  state_q <= INVALIDATE;
               end else if (cpu_req_i.cyc && cpu_req_i.stb && !ack_q) begin
                  state_q <= LOOKUP;
               end
            end
            LOOKUP: begin
               if (cpu_req_i.we) begin
                  state_q <= WRITE_THRU;
               end else if (hit) begin
                  ack_q <= 1'b1;
                  state_q <= IDLE;
               end else begin
                  state_q <= REFILL;
               end
            end
            REFILL, WRITE_THRU: begin
               if (mem_done_i) begin
                  ack_q <= 1'b1;
                  state_q <= IDLE;
               end
            end
            INVALIDATE: begin
               inv_ack_q <= 1'b1;
               state_q <= IDLE;
            end
            default: state_q <= IDLE;
         endcase
      end
   end

   // Victim and tags saved for the refill, read data captured
   always_ff @(posedge clk) begin
      if (state_q == LOOKUP) begin
         dat_q <= hit_dat;
         lru_way_q <= lru_way_i;
         tags_q <= tag_dout_i;
      end
      if (state_q == REFILL && fill_i.valid && fill_i.idx == cpu_word) begin
         dat_q <= fill_i.dat;
      end
   end

   assign cpu_rsp_o = '{ack: ack_q, dat: dat_q};
   assign inv_ack_o = inv_ack_q;

endmodule

//--- hw/dcache_dpram.sv
// Single-clock dual-port RAM with a registered read port.
// Payload type is a parameter, used for both tag sets and data words.
`timescale 1ns/1ns

module dcache_dpram #(
   parameter int ADDR_W = dcache_cfg_pkg::SET_W,
   parameter type T = logic [dcache_cfg_pkg::DATA_W-1:0]
) (
   input  logic              clk,
   input  logic [ADDR_W-1:0] raddr_i,
   input  logic [ADDR_W-1:0] waddr_i,
   input  logic              we_i,
   input  T                  din_i,
   output T                  dout_o
);

   T mem [2**ADDR_W];

   // Read is always enabled
   // Same-address read during a write returns the old word
   always_ff @(posedge clk) begin
      if (we_i) begin
         mem[waddr_i] <= din_i;
      end
      dout_o <= mem[raddr_i];
   end

endmodule

//--- hw/dcache_lru.sv
// Matrix LRU for the cache ways.
// Gives the one-hot least recently used way and the history after an access.
`timescale 1ns/1ns

module dcache_lru (
   input  logic [dcache_cfg_pkg::LRU_W-1:0] current_i,
   input  dcache_cfg_pkg::way_vec_t         access_i,
   output logic [dcache_cfg_pkg::LRU_W-1:0] update_o,
   output dcache_cfg_pkg::way_vec_t         lru_o
);

   // Bit k holds pair (i, j) with i < j
   // Set means way i was used after way j
   always_comb begin
      int k;
      lru_o = '1;
      update_o = current_i;
      k = 0;
      for (int i = 0; i < dcache_cfg_pkg::NUM_WAYS; i++) begin
         for (int j = i + 1; j < dcache_cfg_pkg::NUM_WAYS; j++) begin
            // Newer of the pair cannot be LRU
            if (current_i[k]) begin
               lru_o[i] = 1'b0;
            end else begin
               lru_o[j] = 1'b0;
            end
            // Accessed way becomes newer than every other
            if (access_i[i]) begin
               update_o[k] = 1'b1;
            end else if (access_i[j]) begin
               update_o[k] = 1'b0;
            end
            k++;
         end
      end
   end

endmodule

//--- hw/dcache_mem_port.sv
// Wishbone classic master toward memory.
// Runs a four-word block refill or one write-through write per command.
`timescale 1ns/1ns

module dcache_mem_port (
   input  logic                       clk,
   input  logic                       rst,
   input  dcache_bus_pkg::mem_cmd_t   cmd_i,
   output dcache_bus_pkg::fill_word_t fill_o,
   output logic                       done_o,
   output dcache_bus_pkg::wb_req_t    mem_req_o,
   input  dcache_bus_pkg::wb_rsp_t    mem_rsp_i
);

   logic stb_q;
   logic next_q;
   logic fill_valid_q;
   logic done_q;
   logic we_q;
   logic [dcache_cfg_pkg::BLOCK_W-3:0] cnt_q;
   logic [dcache_cfg_pkg::BLOCK_W-3:0] fill_idx_q;
   logic [dcache_cfg_pkg::DATA_W-1:0] fill_dat_q;
   logic [dcache_cfg_pkg::ADDR_W-1:0] adr_q;
   logic [dcache_cfg_pkg::DATA_W-1:0] dat_q;
   logic [dcache_cfg_pkg::SEL_W-1:0] sel_q;
   logic [dcache_cfg_pkg::ADDR_W-1:0] word_adr;
   logic taken;
   logic last;

   assign taken = stb_q && mem_rsp_i.ack;
   assign last = (cnt_q == dcache_cfg_pkg::WORDS_PER_BLOCK - 1);
   // Refill walks the block from its base, a write uses the CPU address
   assign word_adr = we_q ? adr_q :
                     {adr_q[dcache_cfg_pkg::ADDR_W-1:dcache_cfg_pkg::BLOCK_W], cnt_q, 2'b00};

   always_ff @(posedge clk) begin
      if (rst) begin
         stb_q <= 1'b0;
         next_q <= 1'b0;
         fill_valid_q <= 1'b0;
         done_q <= 1'b0;
      end else begin
         fill_valid_q <= taken && !we_q;
         // Done follows the write ack or the last refill word
         done_q <= (taken && we_q) || (fill_valid_q && fill_idx_q == '1);
         next_q <= 1'b0;
         if (cmd_i.start || next_q) begin
            stb_q <= 1'b1;
         end else if (taken) begin
            // cyc and stb drop for a cycle between words
            stb_q <= 1'b0;
            next_q <= !we_q && !last;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (cmd_i.start) begin
         we_q <= cmd_i.write;
         adr_q <= cmd_i.adr;
         dat_q <= cmd_i.dat;
         sel_q <= cmd_i.sel;
         cnt_q <= '0;
      end else if (taken) begin
         cnt_q <= cnt_q + 1'b1;
      end
      if (taken) begin
         fill_idx_q <= cnt_q;
         fill_dat_q <= mem_rsp_i.dat;
      end
   end

   assign mem_req_o = '{cyc: stb_q, stb: stb_q, we: we_q, sel: we_q ? sel_q : '1,
                        adr: word_adr, dat: dat_q};
   assign fill_o = '{valid: fill_valid_q, idx: fill_idx_q, dat: fill_dat_q};
   assign done_o = done_q;

endmodule

//--- hw/dcache_top.sv
// Data cache top level. CPU Wishbone slave, memory Wishbone master
// and a block invalidate port. Only instances and wires.
`timescale 1ns/1ns

module dcache_top (
   input  logic                     clk,
   input  logic                     rst,
   input  dcache_bus_pkg::wb_req_t  cpu_req_i,
   output dcache_bus_pkg::wb_rsp_t  cpu_rsp_o,
   input  dcache_bus_pkg::inv_req_t inv_req_i,
   output logic                     inv_ack_o,
   output dcache_bus_pkg::wb_req_t  mem_req_o,
   input  dcache_bus_pkg::wb_rsp_t  mem_rsp_i
);

   logic [dcache_cfg_pkg::SET_W-1:0] tag_raddr;
   logic [dcache_cfg_pkg::SET_W-1:0] tag_waddr;
   logic tag_we;
   dcache_cfg_pkg::tag_set_t tag_din;
   dcache_cfg_pkg::tag_set_t tag_dout;
   logic [dcache_cfg_pkg::WAY_ADR_W-1:0] way_raddr;
   logic [dcache_cfg_pkg::WAY_ADR_W-1:0] way_waddr;
   dcache_cfg_pkg::way_vec_t way_we;
   logic [dcache_cfg_pkg::DATA_W-1:0] way_din;
   logic [dcache_cfg_pkg::NUM_WAYS-1:0][dcache_cfg_pkg::DATA_W-1:0] way_dout;
   logic [dcache_cfg_pkg::LRU_W-1:0] lru_cur;
   logic [dcache_cfg_pkg::LRU_W-1:0] lru_next;
   dcache_cfg_pkg::way_vec_t lru_access;
   dcache_cfg_pkg::way_vec_t lru_way;
   dcache_bus_pkg::mem_cmd_t cmd;
   dcache_bus_pkg::fill_word_t fill;
   logic mem_done;

   dcache_ctrl u_ctrl (
      .clk, .rst, .cpu_req_i, .cpu_rsp_o, .inv_req_i, .inv_ack_o,
      .tag_raddr_o(tag_raddr), .tag_waddr_o(tag_waddr), .tag_we_o(tag_we),
      .tag_din_o(tag_din), .tag_dout_i(tag_dout),
      .way_raddr_o(way_raddr), .way_waddr_o(way_waddr), .way_we_o(way_we),
      .way_din_o(way_din), .way_dout_i(way_dout),
      .lru_cur_o(lru_cur), .lru_access_o(lru_access), .lru_next_i(lru_next),
      .lru_way_i(lru_way), .cmd_o(cmd), .fill_i(fill), .mem_done_i(mem_done)
   );

   dcache_mem_port u_mem_port (
      .clk, .rst, .cmd_i(cmd), .fill_o(fill), .done_o(mem_done), .mem_req_o, .mem_rsp_i
   );

   dcache_lru u_lru (
      .current_i(lru_cur), .access_i(lru_access), .update_o(lru_next), .lru_o(lru_way)
   );

   // Tags and LRU history of one set per word
   dcache_dpram #(.ADDR_W(dcache_cfg_pkg::SET_W), .T(dcache_cfg_pkg::tag_set_t)) u_tag_ram (
      .clk, .raddr_i(tag_raddr), .waddr_i(tag_waddr), .we_i(tag_we),
      .din_i(tag_din), .dout_o(tag_dout)
   );

   for (genvar i = 0; i < dcache_cfg_pkg::NUM_WAYS; i++) begin : g_way
      dcache_dpram #(
         .ADDR_W(dcache_cfg_pkg::WAY_ADR_W),
         .T(logic [dcache_cfg_pkg::DATA_W-1:0])
      ) u_way_ram (
         .clk, .raddr_i(way_raddr), .waddr_i(way_waddr), .we_i(way_we[i]),
         .din_i(way_din), .dout_o(way_dout[i])
      );
   end

endmodule

//--- sim/tb_dcache.sv
// Testbench for the two-way write-through data cache.
// Applies a table of reads, writes and invalidates, then checks read data,
// memory read counts and ack latency against values from the cache rules.
`timescale 1ns/1ns

module tb_dcache;

   localparam int TIMEOUT = 200;

   // Three different tags that all map to set 2
   localparam logic [31:0] ADR_A = 32'h0000_1024;
   localparam logic [31:0] ADR_A2 = 32'h0000_1028;
   localparam logic [31:0] ADR_B = 32'h0000_2024;
   localparam logic [31:0] ADR_C = 32'h0000_3024;
   // Block never read before its write
   localparam logic [31:0] ADR_W = 32'h0000_5030;
   localparam logic [31:0] WR_DAT = 32'haabb_ccdd;
   localparam logic [31:0] MISS_DAT = 32'h3344_5566;

   typedef enum logic [1:0] {OP_READ, OP_WRITE, OP_INV} op_t;

   typedef struct {
      op_t op;
      logic [31:0] adr;
      logic [31:0] dat;
      logic [3:0] sel;
      logic [31:0] exp_dat;
      int exp_reads;
      int exp_lat;
   } test_row_t;

   logic clk;
   logic rst;
   dcache_bus_pkg::wb_req_t cpu_req;
   dcache_bus_pkg::wb_rsp_t cpu_rsp;
   dcache_bus_pkg::inv_req_t inv_req;
   logic inv_ack;
   dcache_bus_pkg::wb_req_t mem_req;
   dcache_bus_pkg::wb_rsp_t mem_rsp;
   int mem_reads;
   test_row_t rows[$];
   int errors;

   dcache_top u_dcache_top (
      .clk, .rst, .cpu_req_i(cpu_req), .cpu_rsp_o(cpu_rsp), .inv_req_i(inv_req),
      .inv_ack_o(inv_ack), .mem_req_o(mem_req), .mem_rsp_i(mem_rsp)
   );

   tb_mem_model u_mem_model (
      .clk, .rst, .req_i(mem_req), .rsp_o(mem_rsp), .read_count_o(mem_reads)
   );

   initial clk = 1'b0;
   always #50 clk = ~clk;

   // Memory word that was never written
   function automatic logic [31:0] mem_default(input logic [31:0] adr);
      return {adr[31:2], 2'b00} ^ 32'h5a5a_0000;
   endfunction

   function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] wdat,
                                               input logic [3:0] sel);
      logic [31:0] res;
      res = old;
      for (int b = 0; b < 4; b++) begin
         if (sel[b]) begin
            res[8*b +: 8] = wdat[8*b +: 8];
         end
      end
      return res;
   endfunction

   task automatic add_row(input op_t op, input logic [31:0] adr, input logic [31:0] dat,
                          input logic [3:0] sel, input logic [31:0] exp_dat,
                          input int exp_reads, input int exp_lat);
      test_row_t r;
      r.op = op;
      r.adr = adr;
      r.dat = dat;
      r.sel = sel;
      r.exp_dat = exp_dat;
      r.exp_reads = exp_reads;
      r.exp_lat = exp_lat;
      rows.push_back(r);
   endtask

   // exp_lat of 0 leaves the latency unchecked
   task automatic build_rows();
      logic [31:0] merged_a;
      merged_a = merge_bytes(mem_default(ADR_A), WR_DAT, 4'b0010);
      // Miss and then hits in the same block
      add_row(OP_READ, ADR_A, '0, 4'hf, mem_default(ADR_A), 4, 0);
      add_row(OP_READ, ADR_A, '0, 4'hf, mem_default(ADR_A), 0, 2);
      add_row(OP_READ, ADR_A2, '0, 4'hf, mem_default(ADR_A2), 0, 2);
      // Byte 1 write hit
      add_row(OP_WRITE, ADR_A, WR_DAT, 4'b0010, '0, 0, 0);
      add_row(OP_READ, ADR_A, '0, 4'hf, merged_a, 0, 2);
      // LRU order A, B, A, C evicts B
      add_row(OP_READ, ADR_B, '0, 4'hf, mem_default(ADR_B), 4, 0);
      add_row(OP_READ, ADR_A, '0, 4'hf, merged_a, 0, 2);
      add_row(OP_READ, ADR_C, '0, 4'hf, mem_default(ADR_C), 4, 0);
      add_row(OP_READ, ADR_A, '0, 4'hf, merged_a, 0, 2);
      add_row(OP_READ, ADR_B, '0, 4'hf, mem_default(ADR_B), 4, 0);
      // Refill after invalidate reads the written-through word
      add_row(OP_INV, ADR_A, '0, 4'h0, '0, 0, 2);
      add_row(OP_READ, ADR_A, '0, 4'hf, merged_a, 4, 0);
      // Write miss goes to memory without allocation
      add_row(OP_WRITE, ADR_W, MISS_DAT, 4'hf, '0, 0, 0);
      add_row(OP_READ, ADR_W, '0, 4'hf, MISS_DAT, 4, 0);
   endtask

   // Starts 5 ns after an edge and returns 5 ns after one
   task automatic run_op(input test_row_t r, output logic [31:0] rdat, output int lat,
                         output logic ok);
      if (r.op == OP_INV) begin
         inv_req.cyc = 1'b1;
         inv_req.stb = 1'b1;
         inv_req.adr = r.adr;
      end else begin
         cpu_req.cyc = 1'b1;
         cpu_req.stb = 1'b1;
         cpu_req.we = (r.op == OP_WRITE);
         cpu_req.sel = r.sel;
         cpu_req.adr = r.adr;
         cpu_req.dat = r.dat;
      end
      lat = 0;
      ok = 1'b0;
      rdat = '0;
      while (!ok && lat < TIMEOUT) begin
         @(posedge clk);
         #1;
         lat++;
         if (r.op == OP_INV) begin
            ok = (inv_ack === 1'b1);
         end else begin
            ok = (cpu_rsp.ack === 1'b1);
            rdat = cpu_rsp.dat;
         end
      end
      #4;
      cpu_req = '0;
      inv_req = '0;
      // stb stays low for one cycle between requests
      @(posedge clk);
      #5;
   endtask

   initial begin
      test_row_t r;
      logic [31:0] rdat;
      int lat;
      logic ok;
      logic row_ok;
      int reads_before;
      int passed;
      errors = 0;
      passed = 0;
      rst = 1'b1;
      cpu_req = '0;
      inv_req = '0;
      repeat (2) @(posedge clk);
      #5;
      rst = 1'b0;

      // Valid bits are undefined after reset
      r.op = OP_INV;
      for (int s = 0; s < 2**dcache_cfg_pkg::SET_W; s++) begin
         r.adr = 32'(s) << dcache_cfg_pkg::BLOCK_W;
         run_op(r, rdat, lat, ok);
         if (!ok) begin
            $display("Timeout: invalidate of set %0d got no ack in %0d cycles", s, TIMEOUT);
            errors++;
         end
      end
      $display("all %0d sets invalidated", 2**dcache_cfg_pkg::SET_W);

      build_rows();
      foreach (rows[i]) begin
         reads_before = mem_reads;
         run_op(rows[i], rdat, lat, ok);
         row_ok = 1'b1;
         if (!ok) begin
            $display("Timeout: test %0d got no ack in %0d cycles", i, TIMEOUT);
            row_ok = 1'b0;
         end else begin
            if (rows[i].op == OP_READ && rdat !== rows[i].exp_dat) begin
               $display("[ERROR] %0t: test %0d read data %h, expected %h",
                        $time, i, rdat, rows[i].exp_dat);
               row_ok = 1'b0;
            end
            if (mem_reads - reads_before != rows[i].exp_reads) begin
               $display("[ERROR] %0t: test %0d memory reads %0d, expected %0d",
                        $time, i, mem_reads - reads_before, rows[i].exp_reads);
               row_ok = 1'b0;
            end
            if (rows[i].exp_lat != 0 && lat != rows[i].exp_lat) begin
               $display("[ERROR] %0t: test %0d ack latency %0d, expected %0d",
                        $time, i, lat, rows[i].exp_lat);
               row_ok = 1'b0;
            end
         end
         if (row_ok) begin
            passed++;
         end else begin
            errors++;
         end
         $display("test %0d %s adr %h: %s", i, rows[i].op.name(), rows[i].adr,
                  row_ok ? "pass" : "FAIL");
      end

      $display("%0d of %0d tests passed, %0d errors", passed, rows.size(), errors);
      if (errors == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

//--- sim/tb_mem_model.sv
// Wishbone classic slave memory for the data cache testbench.
// Sparse word store with a fill pattern, LFSR wait states and a read counter.
`timescale 1ns/1ns

module tb_mem_model (
   input  logic                    clk,
   input  logic                    rst,
   input  dcache_bus_pkg::wb_req_t req_i,
   output dcache_bus_pkg::wb_rsp_t rsp_o,
   output int                      read_count_o
);

   // Written words only, keyed by word-aligned byte address
   logic [31:0] mem_q [logic [31:0]];
   logic [31:0] lfsr_q;
   logic busy_q;
   logic [1:0] wait_q;

   // Galois form of x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   // Unwritten words depend on the whole address
   function automatic logic [31:0] word_at(input logic [31:0] adr);
      if (mem_q.exists(adr)) begin
         return mem_q[adr];
      end
      return adr ^ 32'h5a5a_0000;
   endfunction

   always @(posedge clk) begin
      logic [1:0] n;
      logic [31:0] s;
      logic [31:0] wadr;
      logic [31:0] word;
      logic do_access;
      if (rst) begin
         rsp_o <= '0;
         busy_q <= 1'b0;
         wait_q <= '0;
         lfsr_q <= 32'hd0ad;
         read_count_o <= 0;
      end else begin
         do_access = 1'b0;
         rsp_o.ack <= 1'b0;
         // No new access in the ack cycle, the master drops stb next
         if (req_i.cyc && req_i.stb && !rsp_o.ack) begin
            if (!busy_q) begin
               // Two bits, one LFSR step each
               s = lfsr_step(lfsr_q);
               n[0] = s[0];
               s = lfsr_step(s);
               n[1] = s[0];
               lfsr_q <= s;
               if (n == 2'd0) begin
                  do_access = 1'b1;
               end else begin
                  busy_q <= 1'b1;
                  wait_q <= n - 2'd1;
               end
            end else if (wait_q == 2'd0) begin
               busy_q <= 1'b0;
               do_access = 1'b1;
            end else begin
               wait_q <= wait_q - 2'd1;
            end
         end
         if (do_access) begin
            wadr = {req_i.adr[31:2], 2'b00};
            word = word_at(wadr);
            rsp_o.ack <= 1'b1;
            if (req_i.we) begin
               for (int b = 0; b < 4; b++) begin
                  if (req_i.sel[b]) begin
                     word[8*b +: 8] = req_i.dat[8*b +: 8];
                  end
               end
               mem_q[wadr] = word;
            end else begin
               rsp_o.dat <= word;
               read_count_o <= read_count_o + 1;
            end
         end
      end
   end

endmodule
